// File: Makefile
# Verilator build and run for the sound board testbench

VERILATOR := verilator
TOP       := snd_board_tb
FILELIST  := snd_board.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0

SOURCES   := $(shell grep -v '^+' $(FILELIST))
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulator is the result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// File: bench/snd_board_tb.sv
/*
 * Sound board testbench
 * plays the Z80 bus, a ROM model and the chip samples,
 * checks decode, RAM, mailbox, latch and the audio path
 */

`timescale 1ns/1ns

module snd_board_tb;

    localparam int TIMEOUT   = 50;         // clk per wait loop
    localparam int BANK_OFS  = 'h1_0000;   // banked rom area base

    logic        rst, clk;
    logic [15:0] addr;
    logic [7:0]  cpu_dout, cpu_din, rom_data, fm_dout, main_data, main_reply;
    logic        mreq_n, iorq_n, rd_n, wr_n, rom_ok, rom_ready, rom_cs;
    logic        int_n, fm_cs, pcm_cs, pcm_rst, pcm_mdn, pcm_busyn, sample;
    logic [18:0] rom_addr;
    logic signed [15:0] fm_left, fm_right, snd;
    logic signed [8:0]  pcm_raw;
    logic [1:0]  fxlevel;
    logic        enable_fm, enable_psg, main_wr, peak;

    logic [18:0] seen_rom_addr;     // bus state caught during the last read
    logic        seen_rom_cs, seen_fm_cs, seen_pcm_cs;
    int          pole_y;            // filter state, model side
    int          cur_fl, cur_fr;

    snd_board snd_board_i (.*);

    // rom model, upper half of each 128 KB inverted
    function automatic logic [7:0] rom_byte(input logic [18:0] ra);
        return ra[7:0] ^ {8{ra[16]}};
    endfunction

    assign rom_data = rom_byte(rom_addr);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_equal(input string name, input logic signed [31:0] expected,
                               input logic signed [31:0] actual);
        assert (actual === expected) else begin
            $display("error %s: expected %0d, actual %0d", name, expected, actual);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    task automatic cpu_read(input logic io, input logic [15:0] a, output logic [7:0] d);
        int   cnt;
        logic rom_cycle;
        rom_cycle = !io && a < 16'hE000;
        cnt = 0;
        @(posedge clk);
        addr   <= a;
        mreq_n <= io;
        iorq_n <= !io;
        rd_n   <= 1'b0;
        rom_ok <= 1'b0;
        if (rom_cycle) begin
            repeat ($urandom_range(1, 3)) @(posedge clk);   // sdram latency
            rom_ok <= 1'b1;
            do begin
                @(negedge clk);
                cnt++;
                if (cnt > TIMEOUT)
                    abort_run("rom_ready did not rise during a rom read");
            end while (!rom_ready);
            check_equal("rom_ready latency", 2, cnt);   // one clk behind rom_ok
        end
        @(posedge clk);             // read mux takes the data
        @(negedge clk);
        d             = cpu_din;
        seen_rom_addr = rom_addr;
        seen_rom_cs   = rom_cs;
        seen_fm_cs    = fm_cs;
        seen_pcm_cs   = pcm_cs;
        @(posedge clk);
        mreq_n <= 1'b1;
        iorq_n <= 1'b1;
        rd_n   <= 1'b1;
        rom_ok <= 1'b0;
    endtask

    task automatic cpu_write(input logic io, input logic [15:0] a, input logic [7:0] d);
        @(posedge clk);
        addr     <= a;
        cpu_dout <= d;
        mreq_n   <= io;
        iorq_n   <= !io;
        wr_n     <= 1'b0;
        @(posedge clk);             // write lands here
        @(posedge clk);
        mreq_n   <= 1'b1;
        iorq_n   <= 1'b1;
        wr_n     <= 1'b1;
        @(negedge clk);
    endtask

    task automatic main_send(input logic [7:0] v);
        @(posedge clk);
        main_data <= v;
        main_wr   <= 1'b1;
        @(posedge clk);
        main_wr   <= 1'b0;
    endtask

    task automatic wait_int_n(input logic level);
        int cnt;
        cnt = 0;
        @(negedge clk);
        while (int_n !== level) begin
            if (cnt == TIMEOUT)
                abort_run("int_n did not reach the expected level");
            @(negedge clk);
            cnt++;
        end
    endtask

    function automatic int pcm_gain_of(input logic [1:0] fx);
        case (fx)
            2'd0: return 4;
            2'd1: return 6;
            2'd2: return 8;
            default: return 12;
        endcase
    endfunction

    function automatic int pole_step(input int y, input int x);
        return y + (((x - y) * (16 - 10)) >>> 4);   // coefficient 1 - 10/16
    endfunction

    // gain latch, pole and both mixer stages
    task automatic settle_audio();
        repeat (4) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic check_audio(input string name);
        int gf, gp, total, exp_snd;
        bit exp_peak;
        gf = enable_fm ? 16 : 0;
        gp = enable_psg ? pcm_gain_of(fxlevel) : 0;
        total = ((cur_fl * gf) >>> 4) + ((cur_fr * gf) >>> 4)
              + (((pole_y * 128) * gp) >>> 4);        // pcm left aligned to 16 bits
        exp_peak = total > 32767 || total < -32768;
        exp_snd  = total > 32767 ? 32767 : (total < -32768 ? -32768 : total);
        check_equal({name, " snd"}, exp_snd, snd);
        check_equal({name, " peak"}, exp_peak, peak);
    endtask

    task automatic drive_fm(input int fl, input int fr);
        @(posedge clk);
        fm_left  <= 16'(fl);
        fm_right <= 16'(fr);
        cur_fl = fl;
        cur_fr = fr;
    endtask

    initial begin : stim
        logic [7:0]  d, v;
        logic [15:0] a;
        int          b, x, ra;
        int          ram_addrs[$];
        logic [7:0]  ram_shadow [0:2047];

        void'($urandom(32'ha905_4a49));
        rst = 1'b1;
        addr = '0;
        cpu_dout = '0;
        mreq_n = 1'b1;
        iorq_n = 1'b1;
        rd_n = 1'b1;
        wr_n = 1'b1;
        rom_ok = 1'b0;
        fm_dout = 8'h5A;
        fm_left = '0;
        fm_right = '0;
        sample = 1'b0;
        pcm_busyn = 1'b1;
        pcm_raw = '0;
        fxlevel = 2'd0;
        enable_fm = 1'b0;
        enable_psg = 1'b0;
        main_wr = 1'b0;
        main_data = '0;
        pole_y = 0;
        cur_fl = 0;
        cur_fr = 0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        // reset state, strobes idle
        check_equal("reset int_n", 1, int_n);
        check_equal("reset pcm_rst", 1, pcm_rst);
        check_equal("reset pcm_mdn", 1, pcm_mdn);
        check_equal("reset snd", 0, snd);
        check_equal("reset peak", 0, peak);
        check_equal("reset main_reply", 0, main_reply);
        check_equal("idle rom_cs", 0, rom_cs);
        check_equal("idle fm_cs", 0, fm_cs);
        check_equal("idle pcm_cs", 0, pcm_cs);

        // plain rom
        repeat (8) begin
            a = 16'($urandom_range(0, 'h7FFF));
            cpu_read(1'b0, a, d);
            check_equal("rom addr", a, seen_rom_addr);
            check_equal("rom data", rom_byte(19'(a)), d);
        end

        // banked rom, bank from the control latch
        repeat (3) begin
            b = $urandom_range(0, 63);
            cpu_write(1'b1, 16'h0040, 8'(b));
            repeat (4) begin
                a  = 16'($urandom_range('h8000, 'hDFFF));
                ra = BANK_OFS + (b % 16) * 'h4000 + (a % 'h4000);
                cpu_read(1'b0, a, d);
                check_equal("banked cs", 1, seen_rom_cs);
                check_equal("banked addr", ra, seen_rom_addr);
                check_equal("banked data", rom_byte(19'(ra)), d);
            end
        end

        // open bus and the other read sources
        cpu_read(1'b0, 16'hE123, d);
        check_equal("unmapped e000", 'hFF, d);
        cpu_read(1'b0, 16'hF456, d);
        check_equal("unmapped f000", 'hFF, d);
        cpu_read(1'b1, 16'h0001, d);
        check_equal("fm port cs", 1, seen_fm_cs);
        check_equal("fm port data", 'h5A, d);
        for (int k = 0; k < 2; k++) begin
            v = 8'(k);              // busy then idle
            @(posedge clk);
            pcm_busyn <= v[0];
            cpu_read(1'b1, 16'h0080, d);
            check_equal("pcm port cs", 1, seen_pcm_cs);
            check_equal("pcm port data", {v[0], 7'h7F}, d);
        end

        // work ram
        repeat (12) begin
            a = 16'hF800 + 16'($urandom_range(0, 2047));
            v = 8'($urandom);
            ram_addrs.push_back(a);
            ram_shadow[a[10:0]] = v;
            cpu_write(1'b0, a, v);
        end
        foreach (ram_addrs[i]) begin
            a = 16'(ram_addrs[i]);
            cpu_read(1'b0, a, d);
            check_equal("ram readback", ram_shadow[a[10:0]], d);
        end

        // mailbox, port 3 then memory window
        v = 8'($urandom);
        main_send(v);
        wait_int_n(1'b0);
        cpu_read(1'b1, 16'h00C0, d);
        check_equal("mailbox port read", v, d);
        wait_int_n(1'b1);
        v = 8'($urandom);
        main_send(v);
        wait_int_n(1'b0);
        cpu_read(1'b0, 16'hE800 + 16'($urandom_range(0, 'h7FF)), d);
        check_equal("mailbox mem read", v, d);
        wait_int_n(1'b1);
        v = 8'($urandom);
        cpu_write(1'b1, 16'h00C3, v);
        check_equal("reply by port", v, main_reply);
        v = 8'($urandom);
        cpu_write(1'b0, 16'hEC00, v);
        check_equal("reply by mem", v, main_reply);

        // control latch, pcm lines inverted
        for (int i = 0; i < 5; i++) begin
            v = i < 4 ? 8'(i << 6) : 8'($urandom);
            cpu_write(1'b1, 16'h0041, v);
            check_equal("latch pcm_rst", !v[6], pcm_rst);
            check_equal("latch pcm_mdn", !v[7], pcm_mdn);
        end

        // pcm step through the pole, fm silent
        @(posedge clk);
        enable_psg <= 1'b1;
        fxlevel    <= 2'd3;
        drive_fm(0, 0);
        for (int s = 0; s < 2; s++) begin
            x = s == 0 ? $urandom_range(100, 255) : -$urandom_range(100, 256);
            @(posedge clk);
            pcm_raw <= 9'(x);
            repeat (6) begin
                @(posedge clk);
                sample <= 1'b1;
                @(posedge clk);
                sample <= 1'b0;
                pole_y = pole_step(pole_y, x);
                settle_audio();
                check_audio("pole step");
            end
        end

        // gain sweep with held inputs
        drive_fm($urandom_range(0, 16000) - 8000, $urandom_range(0, 16000) - 8000);
        for (int g = 0; g < 16; g++) begin
            @(posedge clk);
            fxlevel    <= 2'(g);
            enable_fm  <= g[2];
            enable_psg <= g[3];
            settle_audio();
            check_audio("gain sweep");
        end

        // clipping both ways
        @(posedge clk);
        enable_fm <= 1'b1;
        drive_fm(30000, 20000);
        settle_audio();
        check_audio("clip high");
        check_equal("clip high peak", 1, peak);
        drive_fm(-30000, -20000);
        settle_audio();
        check_audio("clip low");
        check_equal("clip low peak", 1, peak);

        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: snd_board.f
source/snd_pkg.sv
source/snd_decode.sv
source/snd_ram.sv
source/snd_mailbox.sv
source/snd_pole.sv
source/snd_mixer.sv
source/snd_board.sv
bench/snd_board_tb.sv

// File: source/snd_board.sv
/*
 * Sound board glue, top level
 * decoder, work RAM, mailbox, PCM low-pass and the output mixer
 * around an external Z80, FM chip and ADPCM chip
 */

`timescale 1ns/1ns

module snd_board #(
    parameter int RAM_AW = 11,      // 2 KB work ram
    parameter int PCM_W  = 9        // adpcm output width
) (
    input  logic                        rst,
    input  logic                        clk,
    // z80 bus
    input  logic [snd_pkg::ADDR_W-1:0]  addr,
    input  snd_pkg::byte_t              cpu_dout,
    input  logic                        mreq_n,
    input  logic                        iorq_n,
    input  logic                        rd_n,
    input  logic                        wr_n,
    output snd_pkg::byte_t              cpu_din,
    output logic                        int_n,
    // rom
    output logic [snd_pkg::ROM_AW-1:0]  rom_addr,
    output logic                        rom_cs,
    input  snd_pkg::byte_t              rom_data,
    input  logic                        rom_ok,
    output logic                        rom_ready,  // cpu wait
    // fm chip
    output logic                        fm_cs,
    input  snd_pkg::byte_t              fm_dout,
    input  logic signed [15:0]          fm_left,
    input  logic signed [15:0]          fm_right,
    input  logic                        sample,
    // pcm chip
    output logic                        pcm_cs,
    output logic                        pcm_rst,
    output logic                        pcm_mdn,
    input  logic                        pcm_busyn,
    input  logic signed [PCM_W-1:0]     pcm_raw,
    // options
    input  logic [1:0]                  fxlevel,
    input  logic                        enable_fm,
    input  logic                        enable_psg,
    // main cpu
    input  logic                        main_wr,
    input  snd_pkg::byte_t              main_data,
    output snd_pkg::byte_t              main_reply,
    // audio out
    output logic signed [15:0]          snd,
    output logic                        peak
);
    import snd_pkg::*;

    logic                    ram_cs;
    logic                    mbox_cs;
    byte_t                   ram_dout;
    byte_t                   mbox_dout;
    gain_t                   fm_gain;
    gain_t                   pcm_gain;
    logic signed [PCM_W-1:0] pcm_snd;   // filtered pcm

    snd_decode u_decode (
        .rst        ( rst        ),
        .clk        ( clk        ),
        .addr       ( addr       ),
        .cpu_dout   ( cpu_dout   ),
        .mreq_n     ( mreq_n     ),
        .iorq_n     ( iorq_n     ),
        .rd_n       ( rd_n       ),
        .wr_n       ( wr_n       ),
        .cpu_din    ( cpu_din    ),
        .rom_addr   ( rom_addr   ),
        .rom_cs     ( rom_cs     ),
        .rom_data   ( rom_data   ),
        .rom_ok     ( rom_ok     ),
        .rom_ready  ( rom_ready  ),
        .ram_dout   ( ram_dout   ),
        .fm_dout    ( fm_dout    ),
        .pcm_busyn  ( pcm_busyn  ),
        .mbox_dout  ( mbox_dout  ),
        .ram_cs     ( ram_cs     ),
        .fm_cs      ( fm_cs      ),
        .pcm_cs     ( pcm_cs     ),
        .mbox_cs    ( mbox_cs    ),
        .pcm_rst    ( pcm_rst    ),
        .pcm_mdn    ( pcm_mdn    ),
        .fxlevel    ( fxlevel    ),
        .enable_fm  ( enable_fm  ),
        .enable_psg ( enable_psg ),
        .fm_gain    ( fm_gain    ),
        .pcm_gain   ( pcm_gain   )
    );

    snd_ram #(.RAM_AW(RAM_AW)) u_ram (
        .clk    ( clk                ),
        .cs     ( ram_cs             ),
        .wr_n   ( wr_n               ),
        .addr   ( addr[RAM_AW-1:0]   ),
        .din    ( cpu_dout           ),
        .dout   ( ram_dout           )
    );

    snd_mailbox u_mailbox (
        .rst        ( rst        ),
        .clk        ( clk        ),
        .cs         ( mbox_cs    ),
        .rd_n       ( rd_n       ),
        .wr_n       ( wr_n       ),
        .cpu_dout   ( cpu_dout   ),
        .dout       ( mbox_dout  ),
        .int_n      ( int_n      ),
        .main_wr    ( main_wr    ),
        .main_data  ( main_data  ),
        .main_reply ( main_reply )
    );

    // pcm filter runs at the fm sample rate
    snd_pole #(.PCM_W(PCM_W)) u_pole (
        .rst    ( rst     ),
        .clk    ( clk     ),
        .sample ( sample  ),
        .sin    ( pcm_raw ),
        .sout   ( pcm_snd )
    );

    snd_mixer #(.PCM_W(PCM_W)) u_mixer (
        .rst    ( rst      ),
        .clk    ( clk      ),
        .ch0    ( fm_left  ),
        .ch1    ( fm_right ),
        .ch2    ( pcm_snd  ),
        .gain0  ( fm_gain  ),   // both fm sides share one gain
        .gain1  ( fm_gain  ),
        .gain2  ( pcm_gain ),
        .mixed  ( snd      ),
        .peak   ( peak     )
    );

endmodule

// File: source/snd_decode.sv
/*
 * Sound CPU glue decoder
 * memory and port decode, control latch with rom bank,
 * banked rom address, registered read-data mux, chip gains
 */

`timescale 1ns/1ns

module snd_decode (
    input  logic                        rst,
    input  logic                        clk,
    // z80 bus
    input  logic [snd_pkg::ADDR_W-1:0]  addr,
    input  snd_pkg::byte_t              cpu_dout,
    input  logic                        mreq_n,
    input  logic                        iorq_n,
    input  logic                        rd_n,
    input  logic                        wr_n,
    output snd_pkg::byte_t              cpu_din,
    // rom
    output logic [snd_pkg::ROM_AW-1:0]  rom_addr,
    output logic                        rom_cs,
    input  snd_pkg::byte_t              rom_data,
    input  logic                        rom_ok,
    output logic                        rom_ready,
    // read sources
    input  snd_pkg::byte_t              ram_dout,
    input  snd_pkg::byte_t              fm_dout,
    input  logic                        pcm_busyn,
    input  snd_pkg::byte_t              mbox_dout,
    // selects
    output logic                        ram_cs,
    output logic                        fm_cs,
    output logic                        pcm_cs,
    output logic                        mbox_cs,
    // pcm chip control
    output logic                        pcm_rst,
    output logic                        pcm_mdn,
    // mixer options
    input  logic [1:0]                  fxlevel,
    input  logic                        enable_fm,
    input  logic                        enable_psg,
    output snd_pkg::gain_t              fm_gain,
    output snd_pkg::gain_t              pcm_gain
);
    import snd_pkg::*;

    logic       bank_area;      // 8000-DFFF window
    logic       mbox_mem;       // E800-EFFF
    logic       ctl_cs;         // port 1, control latch
    logic [5:0] bank;           // latch bits 5:0
    logic       rom_ok_l;

    // memory map
    always_comb begin
        bank_area = !mreq_n && addr[15:12] >= 4'h8 && addr[15:12] < 4'hE;
        rom_cs    = (!mreq_n && !addr[15]) || bank_area;
        ram_cs    = !mreq_n && &addr[15:11];            // F800-FFFF
        mbox_mem  = !mreq_n && addr[15:11] == 5'b11101;
    end

    // port map on A7:A6, only one select at a time
    always_comb begin
        fm_cs   = 1'b0;
        ctl_cs  = 1'b0;
        pcm_cs  = 1'b0;
        mbox_cs = mbox_mem;         // iorq and mreq never low together
        if (!iorq_n) begin
            case (addr[7:6])
                2'd0: fm_cs   = 1'b1;
                2'd1: ctl_cs  = 1'b1;
                2'd2: pcm_cs  = 1'b1;
                2'd3: mbox_cs = 1'b1;
                default: ;
            endcase
        end
    end

    // rom address, bank pages are 16 KB
    always_comb begin
        rom_addr = ROM_AW'(addr);
        if (bank_area)
            rom_addr = BANK_BASE + {bank[3:0], addr[13:0]};
    end

    // sdram data must be good for two clk in a row
    assign rom_ready = rom_ok & rom_ok_l;

    // read mux, sampled while rd_n is low and held otherwise
    always_ff @(posedge clk) begin
        if (!rd_n) begin
            if (rom_cs)
                cpu_din <= rom_data;
            else if (ram_cs)
                cpu_din <= ram_dout;
            else if (fm_cs)
                cpu_din <= fm_dout;
            else if (pcm_cs)
                cpu_din <= {pcm_busyn, 7'h7F};  // only busy is readable
            else if (mbox_cs)
                cpu_din <= mbox_dout;
            else
                cpu_din <= 8'hFF;               // open bus
        end
    end

    // control latch and ready history
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank     <= '0;
            pcm_rst  <= 1'b1;   // pcm chip held in reset
            pcm_mdn  <= 1'b1;   // stand alone mode
            rom_ok_l <= 1'b0;
        end else begin
            rom_ok_l <= rom_ok;
            if (ctl_cs && !wr_n) begin
                bank    <= cpu_dout[5:0];
                pcm_rst <= ~cpu_dout[6];
                pcm_mdn <= ~cpu_dout[7];
            end
        end
    end

    // pcm volume from the dip setting
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pcm_gain <= '0;
        end else if (!enable_psg) begin
            pcm_gain <= '0;     // channel muted
        end else begin
            case (fxlevel)
                2'd0: pcm_gain <= PCM_GAIN0;
                2'd1: pcm_gain <= PCM_GAIN1;
                2'd2: pcm_gain <= PCM_GAIN2;
                default: pcm_gain <= PCM_GAIN3;
            endcase
        end
    end

    assign fm_gain = enable_fm ? FM_GAIN : '0;

endmodule

// File: source/snd_mailbox.sv
/*
 * Main to sound CPU mailbox
 * command byte with a full flag that raises the sound interrupt,
 * plus a reply byte written back by the sound CPU
 */

`timescale 1ns/1ns

module snd_mailbox (
    input  logic            rst,
    input  logic            clk,
    // sound cpu side
    input  logic            cs,
    input  logic            rd_n,
    input  logic            wr_n,
    input  snd_pkg::byte_t  cpu_dout,
    output snd_pkg::byte_t  dout,
    output logic            int_n,
    // main cpu side
    input  logic            main_wr,
    input  snd_pkg::byte_t  main_data,
    output snd_pkg::byte_t  main_reply
);
    import snd_pkg::*;

    byte_t cmd;         // last command from the main cpu
    logic  full;
    logic  rd_l;        // rd_n one clk back
    logic  rd_fall;

    assign rd_fall = cs && !rd_n && rd_l;   // first clk of the read

    always_ff @(posedge clk) begin
        if (main_wr)
            cmd <= main_data;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            full       <= 1'b0;
            rd_l       <= 1'b1;
            main_reply <= '0;
        end else begin
            rd_l <= rd_n;
            if (main_wr)
                full <= 1'b1;               // a new command wins over a read
            else if (rd_fall)
                full <= 1'b0;
            if (cs && !wr_n)
                main_reply <= cpu_dout;
        end
    end

    assign dout  = cmd;
    assign int_n = ~full;

endmodule

// File: source/snd_mixer.sv
/*
 * Three channel audio mixer
 * two wide 16 bit channels and one narrow channel, each scaled by
 * a 4.4 gain, summed and clipped to 16 bits with a peak flag
 */

`timescale 1ns/1ns

module snd_mixer #(
    parameter int PCM_W = 9         // width of ch2
) (
    input  logic                    rst,
    input  logic                    clk,
    input  logic signed [15:0]      ch0,
    input  logic signed [15:0]      ch1,
    input  logic signed [PCM_W-1:0] ch2,
    input  snd_pkg::gain_t          gain0,
    input  snd_pkg::gain_t          gain1,
    input  snd_pkg::gain_t          gain2,
    output logic signed [15:0]      mixed,
    output logic                    peak
);
    localparam int PW = 21;     // 16 x 9 bit product after >> 4
    localparam int MW = 25;     // full 16 x 9 bit product
    localparam int SW = PW + 2; // room for three terms

    logic signed [15:0]   chan [3];
    logic         [7:0]   gain [3];
    logic signed [PW-1:0] prod [3];     // stage 1 registers
    logic signed [SW-1:0] sum;
    logic                 over;
    logic                 under;

    // narrow channel is left aligned to 16 bits
    always_comb begin
        chan[0] = ch0;
        chan[1] = ch1;
        chan[2] = {ch2, {(16-PCM_W){1'b0}}};
        gain[0] = gain0;
        gain[1] = gain1;
        gain[2] = gain2;
    end

    // stage 1, scaled channels
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 3; i++)
                prod[i] <= '0;
        end else begin
            for (int i = 0; i < 3; i++)
                prod[i] <= PW'((MW'(chan[i]) * $signed({1'b0, gain[i]})) >>> 4);
        end
    end

    always_comb begin
        sum   = SW'(prod[0]) + SW'(prod[1]) + SW'(prod[2]);
        over  = sum > SW'(32767);
        under = sum < -SW'(32768);
    end

    // stage 2, clip and flag
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mixed <= '0;
            peak  <= 1'b0;
        end else begin
            peak <= over | under;
            if (over)
                mixed <= 16'sh7FFF;
            else if (under)
                mixed <= -16'sh8000;
            else
                mixed <= sum[15:0];
        end
    end

endmodule

// File: source/snd_pkg.sv
/*
 * Sound board shared definitions
 * bus widths, byte and gain types, mixer gains and the
 * fixed coefficient of the PCM low-pass pole
 */

package snd_pkg;

    // z80 side
    localparam int ADDR_W = 16;         // cpu address bus
    localparam int ROM_AW = 19;         // program + sample rom, 512 KB

    typedef logic [7:0] byte_t;         // cpu data byte

    // 4.4 unsigned fixed point, 8'h10 is unity
    typedef logic [7:0] gain_t;

    localparam gain_t FM_GAIN   = 8'h10;   // 1.0

    // pcm gain table, indexed by fxlevel
    localparam gain_t PCM_GAIN0 = 8'h04;   // 0.25
    localparam gain_t PCM_GAIN1 = 8'h06;   // 0.375
    localparam gain_t PCM_GAIN2 = 8'h08;   // 0.5
    localparam gain_t PCM_GAIN3 = 8'h0C;   // 0.75

    // pole a = 10/16, cutoff near 4 kHz at the fm sample rate
    localparam logic [3:0] POLE_A = 4'd10;

    // banked window 8000-DFFF lands above the first 64 KB
    localparam logic [ROM_AW-1:0] BANK_BASE = 19'h1_0000;

endpackage

// File: source/snd_pole.sv
/*
 * One-pole low-pass filter for the PCM channel
 * y += (x - y) * (1 - a), with a = POLE_A/16, one step
 * per fm sample strobe
 */

`timescale 1ns/1ns

module snd_pole #(
    parameter int PCM_W = 9
) (
    input  logic                    rst,
    input  logic                    clk,
    input  logic                    sample,     // fm sample strobe
    input  logic signed [PCM_W-1:0] sin,
    output logic signed [PCM_W-1:0] sout
);
    import snd_pkg::*;

    // 1 - a in sixteenths, positive so a sign bit is added
    localparam logic signed [4:0] COEF = 5'(16 - POLE_A);

    logic signed [PCM_W-1:0] y;
    logic signed [PCM_W:0]   diff;      // one extra bit for x - y
    logic signed [PCM_W+5:0] prod;      // diff times a 5 bit coefficient
    logic signed [PCM_W+5:0] step;
    logic signed [PCM_W+5:0] nxt;

    always_comb begin
        diff = sin - y;
        prod = diff * COEF;
        step = prod >>> 4;          // floor division by 16
        nxt  = y + step;            // stays between y and x
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            y <= '0;
        else if (sample)
            y <= nxt[PCM_W-1:0];
    end

    assign sout = y;

endmodule

// File: source/snd_ram.sv
/*
 * Sound CPU work RAM
 * single port, written on the clock edge, read asynchronously
 * so the registered cpu read mux picks the data up directly
 */

`timescale 1ns/1ns

module snd_ram #(
    parameter int RAM_AW = 11       // 2 KB
) (
    input  logic              clk,
    input  logic              cs,
    input  logic              wr_n,
    input  logic [RAM_AW-1:0] addr,
    input  snd_pkg::byte_t    din,
    output snd_pkg::byte_t    dout
);
    import snd_pkg::*;

    byte_t mem [0:(1<<RAM_AW)-1];

    // z80 holds wr_n low for several clk, rewriting is harmless
    always_ff @(posedge clk) begin
        if (cs && !wr_n)
            mem[addr] <= din;
    end

    assign dout = mem[addr];    // async read

endmodule
